/* files.f */
hdl/fprint_pkg.sv
hdl/crc_fingerprint.sv
hdl/bus_arbiter.sv
hdl/fingerprint_comparator.sv
hdl/multicore_fprint_top.sv
verification/fprint_sva.sv
verification/tb_multicore_fprint.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_multicore_fprint
FILELIST  := files.f
OBJ_DIR   := obj_dir

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_multicore_fprint.sv */
module tb_multicore_fprint;
    import fprint_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int NUM_ROWS   = 6;
    localparam int POOL_WORDS = 24;

    // ************************************************************************
    // stimulus table, one row per task run
    // ************************************************************************

    // keys are packed per core, core 0 in the low nibble
    localparam logic [3:0]  ROW_MASK    [NUM_ROWS] = '{4'b0011, 4'b1100, 4'b0101,
                                                       4'b1111, 4'b0010, 4'b1000};
    localparam logic [15:0] ROW_KEYS    [NUM_ROWS] = '{16'h0033, 16'h5500, 16'h0707,
                                                       16'hA9A9, 16'h00C0, 16'hC000};
    localparam int          ROW_MAX     [NUM_ROWS] = '{0, 0, 3, 0, 0, 0};
    localparam int          ROW_WORDS   [NUM_ROWS] = '{6, 5, 6, 4, 3, 3};
    localparam int          ROW_BASE    [NUM_ROWS] = '{0, 6, 11, 17, 21, 21};
    localparam logic [3:0]  ROW_CORRUPT [NUM_ROWS] = '{4'b0000, 4'b1000, 4'b0000,
                                                       4'b0000, 4'b0000, 4'b0000};
    localparam logic [3:0]  ROW_KEY_A   [NUM_ROWS] = '{4'h3, 4'h5, 4'h7, 4'h9, 4'hC, 4'hC};
    localparam int          ROW_CNT_A   [NUM_ROWS] = '{1, 1, 2, 1, 0, 1};
    localparam logic [3:0]  ROW_KEY_B   [NUM_ROWS] = '{4'h0, 4'h0, 4'h0, 4'hA, 4'h0, 4'h0};
    localparam int          ROW_CNT_B   [NUM_ROWS] = '{0, 0, 0, 1, 0, 0};
    localparam logic        ROW_MATCH   [NUM_ROWS] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};

    logic                 fprint_window_2;
    logic                 rst;
    logic [NUM_CORES-1:0] wr_valid_i;
    data_t                wr_data_i [NUM_CORES];
    logic [NUM_CORES-1:0] wr_ready_o;
    logic [NUM_CORES-1:0] ctl_enable_i;
    key_t                 ctl_key_i [NUM_CORES];
    count_t               ctl_count_max_i [NUM_CORES];
    logic                 result_valid_o;
    key_t                 result_key_o;
    logic                 result_match_o;

    // reference model state
    logic [31:0]          lfsr_q;
    data_t                pool [POOL_WORDS];
    crc_t                 mdl_crc [NUM_CORES];
    int                   mdl_cnt [NUM_CORES];
    int                   mdl_max [NUM_CORES];
    key_t                 mdl_key [NUM_CORES];
    int                   idx [NUM_CORES];
    logic [NUM_CORES-1:0] stall_chk;
    logic [37:0]          exp_seg [$];
    int                   res_cnt [NUM_KEYS];
    int                   res_total;
    logic                 exp_match_now;

    multicore_fprint_top dut (
        .fprint_window_2 (fprint_window_2),
        .rst             (rst),
        .wr_valid_i      (wr_valid_i),
        .wr_data_i       (wr_data_i),
        .wr_ready_o      (wr_ready_o),
        .ctl_enable_i    (ctl_enable_i),
        .ctl_key_i       (ctl_key_i),
        .ctl_count_max_i (ctl_count_max_i),
        .result_valid_o  (result_valid_o),
        .result_key_o    (result_key_o),
        .result_match_o  (result_match_o)
    );

    always #2 fprint_window_2 = ~fprint_window_2;

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string why);
        $display("Error at time %0t: %s", $time, why);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
            stop_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // crc-32, msb first, not reflected
    function automatic crc_t crc_expect(input crc_t crc_in, input data_t word);
        crc_t r;
        logic fb;
        r = crc_in;
        for (int b = 31; b >= 0; b--) begin
            fb = r[31] ^ word[b];
            r  = r << 1;
            if (fb) begin
                r = r ^ CRC_POLY;
            end
        end
        return r;
    endfunction

    task automatic fill_pool();
        data_t w;
        for (int i = 0; i < POOL_WORDS; i++) begin
            w = '0;
            for (int b = 0; b < 32; b++) begin
                lfsr_q = lfsr_next(lfsr_q);
                w      = {w[30:0], lfsr_q[0]};
            end
            pool[i] = w;
        end
    endtask

    task automatic post_segment(input int c);
        exp_seg.push_back({core_id_t'(c), mdl_key[c], mdl_crc[c]});
        mdl_crc[c] = CRC_INIT;
        mdl_cnt[c] = 0;
    endtask

    task automatic accept_word(input int c, input data_t w);
        mdl_crc[c] = crc_expect(mdl_crc[c], w);
        mdl_cnt[c] = mdl_cnt[c] + 1;
        if (mdl_max[c] != 0 && mdl_cnt[c] == mdl_max[c]) begin
            post_segment(c);
            stall_chk[c] = 1'b1;
        end
    endtask

    // ready stays low from the cycle after a count close until the bus takes the message
    task automatic check_stalls();
        logic pending;
        for (int c = 0; c < NUM_CORES; c++) begin
            if (stall_chk[c]) begin
                pending = dut.bus_valid && dut.bus_ready && dut.bus_core == core_id_t'(c);
                for (int i = 0; i < exp_seg.size(); i++) begin
                    if (exp_seg[i][37:36] == core_id_t'(c)) begin
                        pending = 1'b1;
                    end
                end
                if (pending) begin
                    check_value($sformatf("wr_ready_o[%0d]", c), 32'(wr_ready_o[c]), 32'd0);
                end else begin
                    stall_chk[c] = 1'b0;
                end
            end
        end
    endtask

    task automatic run_row(input int r);
        logic [NUM_CORES-1:0] mask;
        logic                 busy;
        int                   cycles;
        data_t                w;
        mask          = ROW_MASK[r];
        exp_match_now = ROW_MATCH[r];
        res_total     = 0;
        for (int k = 0; k < NUM_KEYS; k++) begin
            res_cnt[k] = 0;
        end
        for (int c = 0; c < NUM_CORES; c++) begin
            if (mask[c]) begin
                ctl_enable_i[c]    = 1'b1;
                ctl_key_i[c]       = ROW_KEYS[r][4*c +: 4];
                ctl_count_max_i[c] = count_t'(ROW_MAX[r]);
                mdl_key[c]         = ROW_KEYS[r][4*c +: 4];
                mdl_max[c]         = ROW_MAX[r];
                mdl_crc[c]         = CRC_INIT;
                mdl_cnt[c]         = 0;
                idx[c]             = 0;
            end
        end
        @(negedge fprint_window_2);
        busy   = 1'b1;
        cycles = 0;
        while (busy) begin
            check_stalls();
            busy = 1'b0;
            for (int c = 0; c < NUM_CORES; c++) begin
                if (mask[c] && idx[c] < ROW_WORDS[r]) begin
                    w = pool[ROW_BASE[r] + idx[c]];
                    if (ROW_CORRUPT[r][c] && idx[c] == ROW_WORDS[r] / 2) begin
                        w = w ^ 32'h0000_0100;
                    end
                    wr_valid_i[c] = 1'b1;
                    wr_data_i[c]  = w;
                    // a stalled word is offered again next cycle
                    if (wr_ready_o[c]) begin
                        accept_word(c, w);
                        idx[c] = idx[c] + 1;
                    end
                    busy = 1'b1;
                end else begin
                    wr_valid_i[c] = 1'b0;
                end
            end
            @(negedge fprint_window_2);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("the write phase of a row did not finish");
            end
        end
        // all active cores end the task in the same cycle
        for (int c = 0; c < NUM_CORES; c++) begin
            if (mask[c]) begin
                ctl_enable_i[c] = 1'b0;
                if (mdl_cnt[c] != 0) begin
                    post_segment(c);
                end
            end
        end
        @(negedge fprint_window_2);
        cycles = 0;
        while (exp_seg.size() != 0 || (wr_ready_o & mask) != mask) begin
            check_stalls();
            @(negedge fprint_window_2);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure("posted fingerprints were not all taken from the bus");
            end
        end
        repeat (2) @(negedge fprint_window_2);
        check_value("result count", res_total, ROW_CNT_A[r] + ROW_CNT_B[r]);
        check_value("results of first key", res_cnt[ROW_KEY_A[r]], ROW_CNT_A[r]);
        check_value("results of second key", res_cnt[ROW_KEY_B[r]], ROW_CNT_B[r]);
    endtask

    // ************************************************************************
    // monitors on the shared bus and the result port
    // ************************************************************************

    always @(negedge fprint_window_2) begin : bus_watch
        int found;
        if (!rst && dut.bus_valid && dut.bus_ready) begin
            found = -1;
            for (int i = 0; i < exp_seg.size(); i++) begin
                if (found < 0 && exp_seg[i][37:36] == dut.bus_core) begin
                    found = i;
                end
            end
            if (found < 0) begin
                report_failure("the bus carried a fingerprint that no segment produced");
            end else begin
                check_value("bus_key", 32'(dut.bus_key), 32'(exp_seg[found][35:32]));
                check_value("bus_crc", dut.bus_crc, exp_seg[found][31:0]);
                exp_seg.delete(found);
            end
        end
    end

    always @(negedge fprint_window_2) begin
        if (!rst && result_valid_o) begin
            res_total             = res_total + 1;
            res_cnt[result_key_o] = res_cnt[result_key_o] + 1;
            check_value("result_match_o", 32'(result_match_o), 32'(exp_match_now));
        end
    end

    initial begin
        fprint_window_2 = 1'b0;
        rst             = 1'b1;
        wr_valid_i      = '0;
        ctl_enable_i    = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            wr_data_i[c]       = '0;
            ctl_key_i[c]       = '0;
            ctl_count_max_i[c] = '0;
        end
        stall_chk     = '0;
        exp_match_now = 1'b1;
        res_total     = 0;
        lfsr_q        = 32'd82;
        fill_pool();
        repeat (3) @(posedge fprint_window_2);
        @(negedge fprint_window_2);
        rst = 1'b0;
        check_value("wr_ready_o", 32'(wr_ready_o), 32'hF);
        check_value("result_valid_o", 32'(result_valid_o), 32'd0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* verification/fprint_sva.sv */
module fprint_sva (
    input logic               fprint_window_2,
    input logic               rst,
    input fprint_pkg::grant_t grant_i,
    input fprint_pkg::grant_t req_valid_i,
    input fprint_pkg::grant_t req_ready_i,
    input fprint_pkg::key_t   req_key_i [fprint_pkg::NUM_CORES],
    input fprint_pkg::crc_t   req_crc_i [fprint_pkg::NUM_CORES]
);
    import fprint_pkg::*;

    // one owner of the bus at a time
    a_grant_onehot: assert property (@(posedge fprint_window_2) disable iff (rst)
        $onehot0(grant_i))
        else $error("more than one arbiter grant is high");

    // waiting message keeps its payload until taken
    for (genvar c = 0; c < NUM_CORES; c++) begin : g_hold
        a_msg_hold: assert property (@(posedge fprint_window_2) disable iff (rst)
            req_valid_i[c] && !req_ready_i[c] |=> req_valid_i[c]
                && $stable(req_key_i[c]) && $stable(req_crc_i[c]))
            else $error("message payload changed while waiting for ready");
    end

    // granted unit must be requesting
    a_grant_req: assert property (@(posedge fprint_window_2) disable iff (rst)
        grant_i != '0 |-> (grant_i & req_valid_i) != '0)
        else $error("grant given to a unit without a request");

endmodule

bind bus_arbiter fprint_sva u_sva (
    .fprint_window_2 (fprint_window_2),
    .rst             (rst),
    .grant_i         (grant_q),
    .req_valid_i     (req_valid_i),
    .req_ready_i     (req_ready_o),
    .req_key_i       (req_key_i),
    .req_crc_i       (req_crc_i)
);

/* hdl/multicore_fprint_top.sv */
module multicore_fprint_top (
    input  logic                            fprint_window_2,
    input  logic                            rst,
    input  logic [fprint_pkg::NUM_CORES-1:0] wr_valid_i,
    input  fprint_pkg::data_t               wr_data_i [fprint_pkg::NUM_CORES],
    output logic [fprint_pkg::NUM_CORES-1:0] wr_ready_o,
    input  logic [fprint_pkg::NUM_CORES-1:0] ctl_enable_i,
    input  fprint_pkg::key_t                ctl_key_i [fprint_pkg::NUM_CORES],
    input  fprint_pkg::count_t              ctl_count_max_i [fprint_pkg::NUM_CORES],
    output logic                            result_valid_o,
    output fprint_pkg::key_t                result_key_o,
    output logic                            result_match_o
);
    import fprint_pkg::*;

    // per-core message channels into the arbiter
    grant_t   msg_valid;
    grant_t   msg_ready;
    key_t     msg_key [NUM_CORES];
    crc_t     msg_crc [NUM_CORES];

    // shared fingerprint bus
    logic     bus_valid;
    core_id_t bus_core;
    key_t     bus_key;
    crc_t     bus_crc;
    logic     bus_ready;

    // ************************************************************************
    // one fingerprint unit per core
    // ************************************************************************

    for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
        crc_fingerprint u_fprint (
            .fprint_window_2 (fprint_window_2),
            .rst             (rst),
            .wr_valid_i      (wr_valid_i[c]),
            .wr_data_i       (wr_data_i[c]),
            .wr_ready_o      (wr_ready_o[c]),
            .ctl_enable_i    (ctl_enable_i[c]),
            .ctl_key_i       (ctl_key_i[c]),
            .ctl_count_max_i (ctl_count_max_i[c]),
            .msg_valid_o     (msg_valid[c]),
            .msg_key_o       (msg_key[c]),
            .msg_crc_o       (msg_crc[c]),
            .msg_ready_i     (msg_ready[c])
        );
    end

    // ************************************************************************
    // bus arbitration and comparison
    // ************************************************************************

    bus_arbiter u_arbiter (
        .fprint_window_2 (fprint_window_2),
        .rst             (rst),
        .req_valid_i     (msg_valid),
        .req_key_i       (msg_key),
        .req_crc_i       (msg_crc),
        .req_ready_o     (msg_ready),
        .bus_valid_o     (bus_valid),
        .bus_core_o      (bus_core),
        .bus_key_o       (bus_key),
        .bus_crc_o       (bus_crc),
        .bus_ready_i     (bus_ready)
    );

    fingerprint_comparator u_comparator (
        .fprint_window_2 (fprint_window_2),
        .rst             (rst),
        .bus_valid_i     (bus_valid),
        .bus_core_i      (bus_core),
        .bus_key_i       (bus_key),
        .bus_crc_i       (bus_crc),
        .bus_ready_o     (bus_ready),
        .result_valid_o  (result_valid_o),
        .result_key_o    (result_key_o),
        .result_match_o  (result_match_o)
    );

endmodule

/* hdl/fingerprint_comparator.sv */
module fingerprint_comparator (
    input  logic                 fprint_window_2,
    input  logic                 rst,
    input  logic                 bus_valid_i,
    // source core of the message, not part of the result
    input  fprint_pkg::core_id_t bus_core_i,
    input  fprint_pkg::key_t     bus_key_i,
    input  fprint_pkg::crc_t     bus_crc_i,
    output logic                 bus_ready_o,
    output logic                 result_valid_o,
    output fprint_pkg::key_t     result_key_o,
    output logic                 result_match_o
);
    import fprint_pkg::*;

    cmp_state_t          state_q;
    key_t                in_key_q;
    crc_t                in_crc_q;
    logic [NUM_KEYS-1:0] slot_full_q;
    crc_t                slot_crc_q [NUM_KEYS];

    logic                bus_accept;
    logic                slot_hit;

    assign bus_ready_o = (state_q == IDLE);
    assign bus_accept  = bus_valid_i & bus_ready_o;

    // a full slot means this is the second fingerprint of the key
    assign slot_hit = slot_full_q[in_key_q];

    // result pulse during the compare cycle
    assign result_valid_o = (state_q == COMPARE) & slot_hit;
    assign result_key_o   = in_key_q;
    assign result_match_o = (slot_crc_q[in_key_q] == in_crc_q);

    // ************************************************************************
    // accept / compare sequencing and slot flags
    // ************************************************************************

    always_ff @(posedge fprint_window_2 or posedge rst) begin
        if (rst) begin
            state_q     <= IDLE;
            slot_full_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (bus_accept) begin
                        state_q <= COMPARE;
                    end
                end
                COMPARE: begin
                    // compared pair frees the slot, a first one fills it
                    slot_full_q[in_key_q] <= ~slot_hit;
                    state_q               <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // message register and the stored first fingerprints
    always_ff @(posedge fprint_window_2) begin
        if (bus_accept) begin
            in_key_q <= bus_key_i;
            in_crc_q <= bus_crc_i;
        end
        if (state_q == COMPARE && !slot_hit) begin
            slot_crc_q[in_key_q] <= in_crc_q;
        end
    end

endmodule

/* hdl/bus_arbiter.sv */
module bus_arbiter (
    input  logic                 fprint_window_2,
    input  logic                 rst,
    input  fprint_pkg::grant_t   req_valid_i,
    input  fprint_pkg::key_t     req_key_i [fprint_pkg::NUM_CORES],
    input  fprint_pkg::crc_t     req_crc_i [fprint_pkg::NUM_CORES],
    output fprint_pkg::grant_t   req_ready_o,
    output logic                 bus_valid_o,
    output fprint_pkg::core_id_t bus_core_o,
    output fprint_pkg::key_t     bus_key_o,
    output fprint_pkg::crc_t     bus_crc_o,
    input  logic                 bus_ready_i
);
    import fprint_pkg::*;

    arb_state_t state_q;
    grant_t     grant_q;
    core_id_t   owner_q;
    core_id_t   pick_idx;
    logic       bus_done;

    // lowest numbered requester wins
    always_comb begin
        pick_idx = '0;
        for (int i = NUM_CORES - 1; i >= 0; i--) begin
            if (req_valid_i[i]) begin
                pick_idx = core_id_t'(i);
            end
        end
    end

    // granted unit's payload onto the bus, stamped with its index
    assign bus_valid_o = |(req_valid_i & grant_q);
    assign bus_core_o  = owner_q;
    assign bus_key_o   = req_key_i[owner_q];
    assign bus_crc_o   = req_crc_i[owner_q];

    assign req_ready_o = grant_q & {NUM_CORES{bus_ready_i}};
    assign bus_done    = bus_valid_o & bus_ready_i;

    always_ff @(posedge fprint_window_2 or posedge rst) begin
        if (rst) begin
            state_q <= FREE;
            grant_q <= '0;
            owner_q <= '0;
        end else begin
            case (state_q)
                FREE: begin
                    if (|req_valid_i) begin
                        state_q <= HELD;
                        grant_q <= grant_t'(1) << pick_idx;
                        owner_q <= pick_idx;
                    end
                end
                HELD: begin
                    // grant held until the message is taken
                    if (bus_done) begin
                        state_q <= FREE;
                        grant_q <= '0;
                    end
                end
                default: begin
                    state_q <= FREE;
                    grant_q <= '0;
                end
            endcase
        end
    end

endmodule

/* hdl/crc_fingerprint.sv */
module crc_fingerprint (
    input  logic               fprint_window_2,
    input  logic               rst,
    input  logic               wr_valid_i,
    input  fprint_pkg::data_t  wr_data_i,
    output logic               wr_ready_o,
    input  logic               ctl_enable_i,
    input  fprint_pkg::key_t   ctl_key_i,
    input  fprint_pkg::count_t ctl_count_max_i,
    output logic               msg_valid_o,
    output fprint_pkg::key_t   msg_key_o,
    output fprint_pkg::crc_t   msg_crc_o,
    input  logic               msg_ready_i
);
    import fprint_pkg::*;

    logic   en_q;
    key_t   key_q;
    count_t max_q;
    crc_t   crc_q;
    count_t count_q;
    logic   msg_valid_q;
    key_t   msg_key_q;

    logic   en_rise;
    logic   en_fall;
    logic   wr_accept;
    count_t count_inc;
    crc_t   crc_next;
    logic   close_by_count;
    logic   close_by_disable;
    logic   seg_close;
    logic   msg_done;

    // one full word through the crc, msb of the data first
    function automatic crc_t crc_step(input crc_t crc_in, input data_t data);
        crc_t crc;
        crc = crc_in;
        for (int i = $bits(data_t) - 1; i >= 0; i--) begin
            if (crc[$bits(crc_t)-1] ^ data[i]) begin
                crc = {crc[$bits(crc_t)-2:0], 1'b0} ^ CRC_POLY;
            end else begin
                crc = {crc[$bits(crc_t)-2:0], 1'b0};
            end
        end
        return crc;
    endfunction

    // enable edges, seen against last cycle's level
    assign en_rise = ctl_enable_i & ~en_q;
    assign en_fall = ~ctl_enable_i & en_q;

    // core is stalled while a fingerprint waits for the bus
    assign wr_ready_o = ~msg_valid_q;
    assign wr_accept  = wr_valid_i & wr_ready_o & en_q & ctl_enable_i;

    assign count_inc = count_q + count_t'(1);
    assign crc_next  = crc_step(crc_q, wr_data_i);

    // a zero maximum never matches, so only disable ends such a segment
    assign close_by_count   = wr_accept & (max_q != '0) & (count_inc == max_q);
    assign close_by_disable = en_fall & ~msg_valid_q & (count_q != '0);
    assign seg_close        = close_by_count | close_by_disable;

    assign msg_done = msg_valid_q & msg_ready_i;

    // ************************************************************************
    // segment control and crc accumulation
    // ************************************************************************

    always_ff @(posedge fprint_window_2 or posedge rst) begin
        if (rst) begin
            en_q        <= 1'b0;
            msg_valid_q <= 1'b0;
            crc_q       <= CRC_INIT;
            count_q     <= '0;
        end else begin
            en_q <= ctl_enable_i;
            if (msg_done) begin
                // message taken, next segment starts fresh
                msg_valid_q <= 1'b0;
                crc_q       <= CRC_INIT;
                count_q     <= '0;
            end else begin
                if (wr_accept) begin
                    crc_q   <= crc_next;
                    count_q <= count_inc;
                end
                if (seg_close) begin
                    msg_valid_q <= 1'b1;
                end
            end
        end
    end

    // task key and maximum, latched when the task starts
    always_ff @(posedge fprint_window_2) begin
        if (en_rise) begin
            key_q <= ctl_key_i;
            max_q <= ctl_count_max_i;
        end
        if (seg_close) begin
            msg_key_q <= key_q;
        end
    end

    // crc_q is frozen while the message is pending
    assign msg_valid_o = msg_valid_q;
    assign msg_key_o   = msg_key_q;
    assign msg_crc_o   = crc_q;

endmodule

/* hdl/fprint_pkg.sv */
package fprint_pkg;

    // ************************************************************************
    // system dimensions
    // ************************************************************************

    localparam int NUM_CORES = 4;
    localparam int CORE_W    = 2;

    // core index on the shared bus
    typedef logic [CORE_W-1:0] core_id_t;

    // one request or grant bit per core
    typedef logic [NUM_CORES-1:0] grant_t;

    // store data word of a core
    typedef logic [31:0] data_t;

    // fingerprint value
    typedef logic [31:0] crc_t;

    // task key, 16 keys in all
    typedef logic [3:0] key_t;

    localparam int NUM_KEYS = 16;

    // segment write count and its programmed maximum
    typedef logic [15:0] count_t;

    // ************************************************************************
    // crc-32 constants
    // ************************************************************************

    // msb first, not reflected, no final inversion
    localparam crc_t CRC_POLY = 32'h04C1_1DB7;
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

    // ************************************************************************
    // state machines
    // ************************************************************************

    typedef enum logic {
        IDLE,
        COMPARE
    } cmp_state_t;

    typedef enum logic {
        FREE,
        HELD
    } arb_state_t;

endpackage
